// ==== common/digit_font.mem ====
// One glyph per line, 0 to F. 288 bits, column 11 first, six hex digits per column.
// Bit 0 of each column is row 0.
0000003FFFFC7FFFFE6000066000066000066000066000066000067FFFFE3FFFFC000000
0000003FFFFC3FFFFC000000000000000000000000000000000000000000000000000000
000000000FFC601FFE6018066018066018066018066018066018067FF8063FF000000000
0000003FFFFC7FFFFE601806601806601806601806601806601806601806000000000000
0000003FFFFC3FFFFC001800001800001800001800001800001800001FFC000FFC000000
0000003FF0007FF806601806601806601806601806601806601806601FFE000FFC000000
0000003FF0007FF8066018066018066018066018066018066018067FFFFE3FFFFC000000
0000003FFFFC3FFFFE000006000006000006000006000006000006000006000000000000
0000003FFFFC7FFFFE6018066018066018066018066018066018067FFFFE3FFFFC000000
0000003FFFFC7FFFFE601806601806601806601806601806601806601FFE000FFC000000
0000003FFFFC3FFFFE0018060018060018060018060018060018063FFFFE3FFFFC000000
0000003FF0007FF8006018006018006018006018006018006018007FFFFC3FFFFC000000
0000000000006000066000066000066000066000066000066000067FFFFE3FFFFC000000
0000003FFFFC7FFFFC6018006018006018006018006018006018007FF8003FF000000000
0000000000006018066018066018066018066018066018066018067FFFFE3FFFFC000000
0000000000000018060018060018060018060018060018060018063FFFFE3FFFFC000000

// ==== vlog.f ====
+incdir+common
common/draw_pkg.sv
common/draw_ifs.sv
source/draw_sequencer.sv
source/span_writer.sv
source/sdram_write_port.sv
glyph/glyph_renderer.sv
glyph/digit_font_rom.sv
source/draw_core.sv
verification/draw_core_tb.sv

// ==== Makefile ====
# Verilator build and run for the drawing engine testbench.
VERILATOR   ?= verilator
TOP         ?= draw_core_tb
FILELIST    ?= vlog.f
BUILD_DIR   ?= obj_dir
LOG         ?= sim.log
VFLAGS      ?= --binary --timing -Wno-fatal
PASS_STRING ?= TESTBENCH PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_STRING)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verification/draw_core_tb.sv ====
`default_nettype none

`include "draw_macros.svh"

module draw_core_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int     CLK_PERIOD_NS  = 4;
  localparam int     RESET_CYCLES   = 16;
  localparam int     FRAME_WORDS    = 2 * `FRAME_HLINE_WORDS + 3 * `FRAME_VLINE_WORDS;
  localparam int     COUNTER_WRITES = 8 * `GLYPH_COLS * `GLYPH_ROWS;
  localparam int     COUNTER_RUNS   = 3;
  localparam int     LONG_HOLD      = 30; // Rare slow SDRAM strobe.
  localparam longint TOTAL_WRITES   = `CLEAR_WORDS + FRAME_WORDS
                                    + COUNTER_RUNS * COUNTER_WRITES;
  localparam longint WATCHDOG_CYCLES = TOTAL_WRITES * (LONG_HOLD + 10) + 20000;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        en;
  logic [3:0]  cmd;
  logic [31:0] data;
  logic        draw_done;
  logic [23:0] sdram_wr_addr;
  logic [15:0] sdram_wr_data1, sdram_wr_data2, sdram_wr_data3, sdram_wr_data4;
  logic        sdram_wr_burst;
  logic        sdram_wr_req;
  logic        sdram_wr_done = 1'b0;

  logic [31:0]  lcg_state = 32'hf044;
  logic [287:0] font [16];       // Model copy of the glyph ROM.
  logic [23:0]  exp_addr [$];    // Expected writes, in order.
  logic         exp_burst [$];
  logic [63:0]  exp_word [$];    // data1 in bits 15:0.
  int           done_count = 0;
  int           dones_expected = 0;
  logic         busy = 1'b0;     // Strobe seen, done not yet given.
  int           hold = 0;
  logic [23:0]  snap_addr;
  logic         snap_burst;
  logic [63:0]  snap_word;

  always #(CLK_PERIOD_NS / 2) clk = ~clk;

  draw_core u_dut (
    .clk(clk), .rst_n(rst_n), .en(en), .cmd(cmd), .data(data), .draw_done(draw_done),
    .sdram_wr_addr(sdram_wr_addr), .sdram_wr_data1(sdram_wr_data1),
    .sdram_wr_data2(sdram_wr_data2), .sdram_wr_data3(sdram_wr_data3),
    .sdram_wr_data4(sdram_wr_data4), .sdram_wr_burst(sdram_wr_burst),
    .sdram_wr_req(sdram_wr_req), .sdram_wr_done(sdram_wr_done)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Helpers.
  ////////////////////////////////////////////////////////////////////////////
  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Mostly 0-5 cycles, one strobe in sixteen held long.
  function automatic int pick_hold();
    logic [31:0] r;
    r = next_rand();
    if (r[31:28] == 4'h0) return LONG_HOLD;
    return int'(r[23:16] % 8'd6);
  endfunction

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("TESTBENCH FAILED");
    $fatal(1, "Simulation stopped at the first error.");
  endtask

  task automatic check_field(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    assert (actual === expected) else
      abort_run($sformatf("MISMATCH at %0d ns: %s expected %0h actual %0h",
                          $time, name, expected, actual));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Reference model, one queue entry per SDRAM write.
  ////////////////////////////////////////////////////////////////////////////
  task automatic expect_span(input int unsigned addr, input int unsigned stride,
                             input int unsigned count, input logic [15:0] color);
    for (int unsigned i = 0; i < count; i++) begin
      exp_addr.push_back(24'(addr + i * stride));
      exp_burst.push_back(1'b1);
      exp_word.push_back({4{color}}); // Same colour in all four pixels.
    end
  endtask

  task automatic expect_frame();
    expect_span(`FRAME_TOP_ADDR, `PIXELS_PER_WORD, `FRAME_HLINE_WORDS, `COLOR_GREEN);
    expect_span(`FRAME_BOTTOM_ADDR, `PIXELS_PER_WORD, `FRAME_HLINE_WORDS, `COLOR_GREEN);
    expect_span(`FRAME_LEFT_ADDR, `SCREEN_W, `FRAME_VLINE_WORDS, `COLOR_GREEN);
    expect_span(`FRAME_RIGHT_ADDR, `SCREEN_W, `FRAME_VLINE_WORDS, `COLOR_GREEN);
    expect_span(`FRAME_MID_ADDR, `SCREEN_W, `FRAME_VLINE_WORDS, `COLOR_YELLOW);
  endtask

  // Column c goes down the screen, row r goes left.
  task automatic expect_glyph(input logic [3:0] idx, input int unsigned origin);
    logic [287:0] g;
    logic [15:0]  px;
    g = font[idx];
    for (int c = 0; c < `GLYPH_COLS; c++) begin
      for (int r = 0; r < `GLYPH_ROWS; r++) begin
        px = g[24 * c + r] ? `COLOR_GREEN : `COLOR_BLACK;
        exp_addr.push_back(24'(origin + c * `SCREEN_W - r));
        exp_burst.push_back(1'b0);
        exp_word.push_back({48'h0, px}); // Words 1-3 zero.
      end
    end
  endtask

  task automatic expect_counter(input logic [31:0] value);
    for (int k = 0; k < 8; k++) begin
      expect_glyph(value[4 * (7 - k) +: 4], `COUNTER_ORIGIN + k * `DIGIT_STEP);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // SDRAM responder and write monitor. Everything sampled on the falling edge.
  ////////////////////////////////////////////////////////////////////////////
  task automatic check_write();
    logic [23:0] e_addr;
    logic        e_burst;
    logic [63:0] e_word;
    assert (exp_addr.size() != 0) else
      abort_run("SDRAM write request seen while the model expects no write.");
    e_addr  = exp_addr.pop_front();
    e_burst = exp_burst.pop_front();
    e_word  = exp_word.pop_front();
    check_field("sdram_wr_addr", e_addr, sdram_wr_addr);
    check_field("sdram_wr_burst", e_burst, sdram_wr_burst);
    check_field("sdram_wr_data1", e_word[15:0], sdram_wr_data1);
    check_field("sdram_wr_data2", e_word[31:16], sdram_wr_data2);
    check_field("sdram_wr_data3", e_word[47:32], sdram_wr_data3);
    check_field("sdram_wr_data4", e_word[63:48], sdram_wr_data4);
  endtask

  always @(negedge clk) begin : sdram_responder
    if (!rst_n) begin
      sdram_wr_done = 1'b0;
      busy          = 1'b0;
    end else begin
      if (draw_done) begin
        assert (exp_addr.size() == 0) else
          abort_run("draw_done pulsed before all expected writes were seen.");
        assert (done_count < dones_expected) else
          abort_run("draw_done pulsed with no command outstanding.");
        done_count++;
      end
      if (sdram_wr_done) begin
        sdram_wr_done = 1'b0; // Taken at the last rising edge.
        busy          = 1'b0;
      end else if (sdram_wr_req) begin
        if (!busy) begin
          busy       = 1'b1;
          snap_addr  = sdram_wr_addr;
          snap_burst = sdram_wr_burst;
          snap_word  = {sdram_wr_data4, sdram_wr_data3, sdram_wr_data2, sdram_wr_data1};
          check_write();
          hold = pick_hold();
        end else begin
          // Fields must hold for the whole strobe.
          check_field("sdram_wr_addr", snap_addr, sdram_wr_addr);
          check_field("sdram_wr_burst", snap_burst, sdram_wr_burst);
          check_field("sdram_wr_data", snap_word,
                      {sdram_wr_data4, sdram_wr_data3, sdram_wr_data2, sdram_wr_data1});
        end
        if (hold == 0) sdram_wr_done = 1'b1;
        else hold--;
      end else begin
        assert (!busy) else
          abort_run("sdram_wr_req dropped before sdram_wr_done was given.");
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus.
  ////////////////////////////////////////////////////////////////////////////
  task automatic run_command(input logic [3:0] code, input logic [31:0] value);
    @(negedge clk);
    cmd = code;
    data = value;
    en = 1'b1;
    dones_expected++;
    @(negedge clk);
    en   = 1'b0;
    data = ~value; // Sequencer must use the latched word.
    wait (done_count == dones_expected);
    repeat (30) @(negedge clk); // A second pulse fails in the monitor.
  endtask

  initial begin : main
    logic [31:0] words [COUNTER_RUNS];
    rst_n = 1'b0;
    en    = 1'b0;
    cmd   = 4'd0;
    data  = 32'd0;
    $readmemh("common/digit_font.mem", font);
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    foreach (words[i]) words[i] = next_rand();

    repeat (20) begin // Quiet until en.
      @(negedge clk);
      assert (!sdram_wr_req && !draw_done) else
        abort_run("sdram_wr_req or draw_done went high with en low after reset.");
    end

    expect_span(0, `PIXELS_PER_WORD, `CLEAR_WORDS, `COLOR_BLACK);
    run_command(4'd0, 32'd0);
    expect_frame();
    run_command(4'd1, 32'd0);
    foreach (words[i]) begin
      expect_counter(words[i]);
      run_command(4'd2, words[i]);
    end

    // Unknown command, nothing may happen.
    @(negedge clk);
    cmd = 4'd5;
    en  = 1'b1;
    repeat (200) @(negedge clk);
    en = 1'b0;
    repeat (20) @(negedge clk);

    $display("TESTBENCH PASSED");
    $finish;
  end

  initial begin : watchdog
    #(WATCHDOG_CYCLES * CLK_PERIOD_NS);
    abort_run("Watchdog expired, the DUT stopped making progress.");
  end

endmodule

`default_nettype wire

// ==== source/draw_core.sv ====
`default_nettype none

module draw_core import draw_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        en,
  input  logic [3:0]  cmd,        // Codes 3-15 ignored.
  input  logic [31:0] data,       // Counter value for command 2.
  output logic        draw_done,
  output pixel_addr_t sdram_wr_addr,
  output rgb565_t     sdram_wr_data1,
  output rgb565_t     sdram_wr_data2,
  output rgb565_t     sdram_wr_data3,
  output rgb565_t     sdram_wr_data4,
  output logic        sdram_wr_burst,
  output logic        sdram_wr_req,
  input  logic        sdram_wr_done
);

  span_job_if    span_job ();
  glyph_job_if   glyph_job ();
  pixel_write_if span_px ();
  pixel_write_if glyph_px ();

  glyph_idx_t  font_idx;
  glyph_bits_t font_bits;

  draw_sequencer u_sequencer (.clk(clk), .rst_n(rst_n), .en(en),
    .cmd(draw_cmd_e'(cmd)), .data(data), .draw_done(draw_done),
    .span(span_job), .glyph(glyph_job));

  span_writer u_span (.clk(clk), .rst_n(rst_n), .job(span_job), .wr(span_px));

  glyph_renderer u_glyph (.clk(clk), .rst_n(rst_n), .job(glyph_job),
    .font_idx(font_idx), .font_bits(font_bits), .wr(glyph_px));

  digit_font_rom u_font (.clk(clk), .idx(font_idx), .bits(font_bits));

  sdram_write_port u_port (.clk(clk), .rst_n(rst_n),
    .span_wr(span_px), .glyph_wr(glyph_px),
    .sdram_wr_addr(sdram_wr_addr), .sdram_wr_data1(sdram_wr_data1),
    .sdram_wr_data2(sdram_wr_data2), .sdram_wr_data3(sdram_wr_data3),
    .sdram_wr_data4(sdram_wr_data4), .sdram_wr_burst(sdram_wr_burst),
    .sdram_wr_req(sdram_wr_req), .sdram_wr_done(sdram_wr_done));

endmodule

`default_nettype wire

// ==== glyph/digit_font_rom.sv ====
`default_nettype none

module digit_font_rom import draw_pkg::*; (
  input  logic        clk,
  input  glyph_idx_t  idx,
  output glyph_bits_t bits // One cycle after idx.
);

  localparam int GLYPHS = 2 ** $bits(glyph_idx_t); // 0-F.

  glyph_bits_t rom [GLYPHS];

  // One 288-bit glyph per line, 72 hex digits.
  initial begin
    $readmemh("common/digit_font.mem", rom);
  end

  always_ff @(posedge clk) begin
    bits <= rom[idx];
  end

endmodule

`default_nettype wire

// ==== glyph/glyph_renderer.sv ====
`default_nettype none

`include "draw_macros.svh"

module glyph_renderer import draw_pkg::*; (
  input  logic          clk,
  input  logic          rst_n,
  glyph_job_if.worker   job,
  output glyph_idx_t    font_idx,
  input  glyph_bits_t   font_bits,
  pixel_write_if.client wr
);

  localparam logic [3:0] COL_LAST = 4'(`GLYPH_COLS - 1);
  localparam logic [4:0] ROW_LAST = 5'(`GLYPH_ROWS - 1);
  // From the bottom of one column to the top of the next, one row down.
  localparam pixel_addr_t COL_STEP = pixel_addr_t'(`SCREEN_W + `GLYPH_ROWS - 1);

  typedef enum logic [1:0] {GR_IDLE, GR_LOAD, GR_WRITE, GR_GAP} gr_state_e;

  gr_state_e   state;
  logic [3:0]  col;
  logic [4:0]  row;
  logic        finished_q;
  logic        last_pixel;
  glyph_bits_t bits_q;   // Shifted, bit 0 is the current pixel.
  pixel_addr_t pix_addr;
  rgb565_t     pix_color;

  assign last_pixel = (col == COL_LAST) && (row == ROW_LAST);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= GR_IDLE;
      col        <= '0;
      row        <= '0;
      finished_q <= 1'b0;
    end else begin
      finished_q <= 1'b0;
      case (state)
        GR_IDLE: if (job.start) begin
          col   <= '0;
          row   <= '0;
          state <= GR_LOAD; // ROM output valid next cycle.
        end
        GR_LOAD: state <= GR_WRITE;
        GR_WRITE: if (wr.ack) begin
          if (last_pixel) begin
            finished_q <= 1'b1;
            state      <= GR_IDLE;
          end else begin
            state <= GR_GAP;
            if (row == ROW_LAST) begin
              row <= '0;
              col <= col + 4'd1;
            end else begin
              row <= row + 5'd1;
            end
          end
        end
        default: state <= GR_WRITE;
      endcase
    end
  end

  // Bits run column by column, top row first, so one shift per pixel.
  always_ff @(posedge clk) begin
    if (state == GR_IDLE && job.start) begin
      pix_addr <= job.origin;
    end else if (state == GR_LOAD) begin
      bits_q <= font_bits;
    end else if (state == GR_WRITE && wr.ack) begin
      bits_q <= bits_q >> 1;
      if (row == ROW_LAST) begin
        pix_addr <= pix_addr + COL_STEP;
      end else begin
        pix_addr <= pix_addr - 1'b1; // Next row goes left in x.
      end
    end
  end

  assign pix_color = bits_q[0] ? `COLOR_GREEN : `COLOR_BLACK;
  assign font_idx  = job.glyph; // Held by the sequencer for the whole job.

  always_comb begin
    wr.word    = '0;         // Words 1-3 unused.
    wr.word[0] = pix_color;
  end

  assign wr.req       = (state == GR_WRITE);
  assign wr.addr      = pix_addr;
  assign wr.burst     = 1'b0;   // Single pixel.
  assign job.finished = finished_q;

endmodule

`default_nettype wire

// ==== source/sdram_write_port.sv ====
`default_nettype none

module sdram_write_port import draw_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  pixel_write_if.port span_wr,
  pixel_write_if.port glyph_wr,
  output pixel_addr_t sdram_wr_addr,
  output rgb565_t     sdram_wr_data1,
  output rgb565_t     sdram_wr_data2,
  output rgb565_t     sdram_wr_data3,
  output rgb565_t     sdram_wr_data4,
  output logic        sdram_wr_burst,
  output logic        sdram_wr_req,
  input  logic        sdram_wr_done
);

  logic span_ack_q;
  logic glyph_ack_q;
  logic owner_glyph; // Who gets the ack.
  logic ready;
  logic take_span;
  logic take_glyph;

  // No accept in the ack cycle, the client still holds its old req there.
  assign ready      = !sdram_wr_req && !span_ack_q && !glyph_ack_q;
  assign take_span  = ready && span_wr.req;                  // Span wins.
  assign take_glyph = ready && !span_wr.req && glyph_wr.req;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sdram_wr_req <= 1'b0;
      span_ack_q   <= 1'b0;
      glyph_ack_q  <= 1'b0;
      owner_glyph  <= 1'b0;
    end else begin
      span_ack_q  <= sdram_wr_req && sdram_wr_done && !owner_glyph;
      glyph_ack_q <= sdram_wr_req && sdram_wr_done && owner_glyph;
      if (sdram_wr_req && sdram_wr_done) begin
        sdram_wr_req <= 1'b0; // Strobe ends on done.
      end else if (take_span || take_glyph) begin
        sdram_wr_req <= 1'b1;
        owner_glyph  <= take_glyph;
      end
    end
  end

  // SDRAM fields, stable for the whole strobe.
  always_ff @(posedge clk) begin
    if (take_span) begin
      sdram_wr_addr  <= span_wr.addr;
      sdram_wr_burst <= span_wr.burst;
      {sdram_wr_data4, sdram_wr_data3, sdram_wr_data2, sdram_wr_data1} <= span_wr.word;
    end else if (take_glyph) begin
      sdram_wr_addr  <= glyph_wr.addr;
      sdram_wr_burst <= glyph_wr.burst;
      {sdram_wr_data4, sdram_wr_data3, sdram_wr_data2, sdram_wr_data1} <= glyph_wr.word;
    end
  end

  assign span_wr.ack  = span_ack_q;
  assign glyph_wr.ack = glyph_ack_q;

endmodule

`default_nettype wire

// ==== source/span_writer.sv ====
`default_nettype none

`include "draw_macros.svh"

module span_writer import draw_pkg::*; (
  input  logic          clk,
  input  logic          rst_n,
  span_job_if.worker    job,
  pixel_write_if.client wr
);

  typedef enum logic [1:0] {SW_IDLE, SW_WRITE, SW_GAP} sw_state_e;

  sw_state_e   state;
  pixel_addr_t left_q;   // Words still to write.
  logic        finished_q;
  pixel_addr_t addr_q;
  pixel_addr_t stride_q;
  rgb565_t     color_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= SW_IDLE;
      left_q     <= '0;
      finished_q <= 1'b0;
    end else begin
      finished_q <= 1'b0;
      case (state)
        SW_IDLE: if (job.start) begin
          left_q <= job.count;
          state  <= SW_WRITE; // First req next cycle.
        end
        SW_WRITE: if (wr.ack) begin
          left_q <= left_q - 1'b1;
          if (left_q == pixel_addr_t'(1)) begin
            finished_q <= 1'b1;
            state      <= SW_IDLE;
          end else begin
            state <= SW_GAP; // Req low for one cycle.
          end
        end
        default: state <= SW_WRITE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == SW_IDLE && job.start) begin
      addr_q   <= job.addr;
      stride_q <= job.stride;
      color_q  <= job.color;
    end else if (state == SW_WRITE && wr.ack) begin
      addr_q <= addr_q + stride_q; // Next word.
    end
  end

  assign wr.req       = (state == SW_WRITE);
  assign wr.addr      = addr_q;
  assign wr.word      = {`PIXELS_PER_WORD{color_q}};
  assign wr.burst     = 1'b1;
  assign job.finished = finished_q;

endmodule

`default_nettype wire

// ==== source/draw_sequencer.sv ====
`default_nettype none

`include "draw_macros.svh"

module draw_sequencer import draw_pkg::*; (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           en,
  input  draw_cmd_e      cmd,
  input  logic [31:0]    data,
  output logic           draw_done,
  span_job_if.sequencer  span,
  glyph_job_if.sequencer glyph
);

  localparam logic [2:0] LAST_SPAN  = 3'd4; // Five frame lines.
  localparam logic [2:0] LAST_DIGIT = 3'd7; // Eight digits.

  typedef enum logic [2:0] {
    SQ_IDLE, SQ_SPAN_GO, SQ_SPAN_WAIT, SQ_GLYPH_GO, SQ_GLYPH_WAIT, SQ_DONE
  } sq_state_e;

  sq_state_e   state;
  draw_cmd_e   cmd_q;
  logic [31:0] data_q;  // Counter word, frozen for the whole command.
  logic [2:0]  step;    // Span or digit number.
  logic [2:0]  nib_sel;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state  <= SQ_IDLE;
      cmd_q  <= CMD_CLEAR;
      data_q <= '0;
      step   <= '0;
    end else begin
      case (state)
        SQ_IDLE: if (en) begin
          cmd_q  <= cmd;
          data_q <= data;
          step   <= '0;
          case (cmd)
            CMD_CLEAR, CMD_FRAME: state <= SQ_SPAN_GO;
            CMD_COUNTER:          state <= SQ_GLYPH_GO;
            default:              state <= SQ_IDLE; // Unknown code, no writes.
          endcase
        end
        SQ_SPAN_GO:  state <= SQ_SPAN_WAIT;
        SQ_SPAN_WAIT: if (span.finished) begin
          if (cmd_q == CMD_CLEAR || step == LAST_SPAN) begin
            state <= SQ_DONE;
          end else begin
            step  <= step + 3'd1;
            state <= SQ_SPAN_GO;
          end
        end
        SQ_GLYPH_GO: state <= SQ_GLYPH_WAIT;
        SQ_GLYPH_WAIT: if (glyph.finished) begin
          if (step == LAST_DIGIT) begin
            state <= SQ_DONE;
          end else begin
            step  <= step + 3'd1;
            state <= SQ_GLYPH_GO;
          end
        end
        default: state <= SQ_IDLE; // SQ_DONE lasts one cycle.
      endcase
    end
  end

  assign span.start  = (state == SQ_SPAN_GO);
  assign glyph.start = (state == SQ_GLYPH_GO);
  assign draw_done   = (state == SQ_DONE);

  ////////////////////////////////////////////////////////////////////////////
  // Span table. Clear is one span, frame is top, bottom, left, right, mid.
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    span.addr   = '0;
    span.stride = pixel_addr_t'(`PIXELS_PER_WORD); // Horizontal run.
    span.count  = pixel_addr_t'(`CLEAR_WORDS);
    span.color  = `COLOR_BLACK;
    if (cmd_q == CMD_FRAME) begin
      span.color = `COLOR_GREEN;
      span.count = pixel_addr_t'(`FRAME_VLINE_WORDS);
      span.stride = pixel_addr_t'(`SCREEN_W); // One row per word.
      case (step)
        3'd0: begin
          span.addr   = pixel_addr_t'(`FRAME_TOP_ADDR);
          span.stride = pixel_addr_t'(`PIXELS_PER_WORD);
          span.count  = pixel_addr_t'(`FRAME_HLINE_WORDS);
        end
        3'd1: begin
          span.addr   = pixel_addr_t'(`FRAME_BOTTOM_ADDR);
          span.stride = pixel_addr_t'(`PIXELS_PER_WORD);
          span.count  = pixel_addr_t'(`FRAME_HLINE_WORDS);
        end
        3'd2: span.addr = pixel_addr_t'(`FRAME_LEFT_ADDR);
        3'd3: span.addr = pixel_addr_t'(`FRAME_RIGHT_ADDR);
        default: begin
          span.addr  = pixel_addr_t'(`FRAME_MID_ADDR);
          span.color = `COLOR_YELLOW; // Centre line.
        end
      endcase
    end
  end

  // Most significant nibble is drawn first.
  assign nib_sel      = LAST_DIGIT - step;
  assign glyph.glyph  = data_q[{nib_sel, 2'b00} +: 4];
  assign glyph.origin = pixel_addr_t'(`COUNTER_ORIGIN)
                      + pixel_addr_t'(step) * pixel_addr_t'(`DIGIT_STEP);

endmodule

`default_nettype wire

// ==== common/draw_ifs.sv ====
`default_nettype none

// Single SDRAM write from one drawing client.
interface pixel_write_if import draw_pkg::*; ();
  logic        req;   // Held with the fields until ack.
  pixel_addr_t addr;
  pixel_word_t word;
  logic        burst; // 0: word 0 only, rest zero.
  logic        ack;   // One cycle.

  modport client (output req, addr, word, burst, input ack);
  modport port (input req, addr, word, burst, output ack);
endinterface

// Run of four-pixel words at a fixed stride.
interface span_job_if import draw_pkg::*; ();
  logic        start;    // One-cycle pulse.
  pixel_addr_t addr;     // First pixel.
  pixel_addr_t stride;   // Pixels between words.
  pixel_addr_t count;    // Words, same width as an address.
  rgb565_t     color;
  logic        finished; // One cycle after the last ack.

  modport sequencer (output start, addr, stride, count, color, input finished);
  modport worker (input start, addr, stride, count, color, output finished);
endinterface

// One font glyph at a pixel origin.
interface glyph_job_if import draw_pkg::*; ();
  logic        start;
  glyph_idx_t  glyph;
  pixel_addr_t origin;   // Pixel of column 0, row 0.
  logic        finished;

  modport sequencer (output start, glyph, origin, input finished);
  modport worker (input start, glyph, origin, output finished);
endinterface

`default_nettype wire

// ==== common/draw_pkg.sv ====
`default_nettype none

`include "draw_macros.svh"

////////////////////////////////////////////////////////////////////////////
// Shared types of the drawing engine.
////////////////////////////////////////////////////////////////////////////
package draw_pkg;

  typedef logic [23:0] pixel_addr_t; // Bank(2)+row(13)+column(9).
  typedef logic [15:0] rgb565_t;     // R5 G6 B5.

  // One SDRAM write. Element 0 goes out on data1.
  typedef rgb565_t [`PIXELS_PER_WORD-1:0] pixel_word_t;

  // Command codes, the rest of the 4-bit range is ignored.
  typedef enum logic [3:0] {
    CMD_CLEAR   = 4'd0, // Black screen.
    CMD_FRAME   = 4'd1, // Fixed frame lines.
    CMD_COUNTER = 4'd2  // Eight hex digits from data.
  } draw_cmd_e;

  // 24x12 glyph. Three bytes per column, bit 24*col+row, LSB is top row.
  typedef logic [`GLYPH_COLS*`GLYPH_ROWS-1:0] glyph_bits_t;
  typedef logic [3:0] glyph_idx_t; // One nibble, one glyph.

endpackage

`default_nettype wire

// ==== common/draw_macros.svh ====
`ifndef DRAW_MACROS_SVH
`define DRAW_MACROS_SVH

// Panel geometry. Portrait, one RGB565 pixel per address.
`define SCREEN_W          480
`define SCREEN_H          800
`define PIXELS_PER_WORD   4     // Pixels per SDRAM write.
`define CLEAR_WORDS       (`SCREEN_W * `SCREEN_H / `PIXELS_PER_WORD)

// Frame image, start pixels as y*480+x.
`define FRAME_TOP_ADDR    4810   // (10,10).
`define FRAME_BOTTOM_ADDR 379210 // (10,790).
`define FRAME_LEFT_ADDR   4810   // (10,10).
`define FRAME_RIGHT_ADDR  5266   // (466,10), last span ends at x=469.
`define FRAME_MID_ADDR    5040   // (240,10).
`define FRAME_HLINE_WORDS 115    // 460 pixels wide.
`define FRAME_VLINE_WORDS 780    // Rows 10 to 789.

// Counter digits. Origin (180,680), each digit twelve rows further on.
`define COUNTER_ORIGIN    326580
`define DIGIT_STEP        5760
`define GLYPH_COLS        12
`define GLYPH_ROWS        24

`define COLOR_BLACK       16'h0000
`define COLOR_GREEN       16'h07E0
`define COLOR_YELLOW      16'hFFE0
`endif
